//--- common/rv_pkg.sv
// rv32i subset shared types
package rv_pkg;

    // data path width
    localparam int XLEN = 32;

    // instructions the cores understand
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_ADDI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL,
        OP_ILLEGAL
    } opcode_t;

    // alu functions
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // decoder output, one instruction
    typedef struct packed {
        opcode_t         opcode;
        alu_op_t         alu_op;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        logic            rd_we;
        logic            use_imm;
    } decoded_t;

    // one retired instruction, unit of comparison
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            rd_we;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
    } retire_t;

    // instruction memory write from outside
    typedef struct packed {
        logic            en;
        logic [7:0]      addr;
        logic [XLEN-1:0] data;
    } imem_load_t;

endpackage

//--- hw/rv_decoder.sv
// rv32i subset decoder
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::XLEN-1:0] instr,
    output rv_pkg::decoded_t        dec
);
    import rv_pkg::*;

    logic [6:0]      opc;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opc    = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.opcode = OP_ILLEGAL;
        dec.alu_op = ALU_ADD;
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        case (opc)
            // register ops
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: dec.opcode = OP_ADD;
                    10'b0100000_000: begin
                        dec.opcode = OP_SUB;
                        dec.alu_op = ALU_SUB;
                    end
                    10'b0000000_111: begin
                        dec.opcode = OP_AND;
                        dec.alu_op = ALU_AND;
                    end
                    10'b0000000_110: begin
                        dec.opcode = OP_OR;
                        dec.alu_op = ALU_OR;
                    end
                    default: dec.opcode = OP_ILLEGAL;
                endcase
                dec.rd_we = (dec.opcode != OP_ILLEGAL);
            end
            7'b0010011: begin
                if (funct3 == 3'b000) begin
                    dec.opcode  = OP_ADDI;
                    dec.imm     = imm_i;
                    dec.use_imm = 1'b1;
                    dec.rd_we   = 1'b1;
                end
            end
            // word load and store only
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    dec.opcode  = OP_LW;
                    dec.imm     = imm_i;
                    dec.use_imm = 1'b1;
                    dec.rd_we   = 1'b1;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    dec.opcode  = OP_SW;
                    dec.imm     = imm_s;
                    dec.use_imm = 1'b1;
                end
            end
            7'b1100011: begin
                if (funct3 == 3'b000) begin
                    dec.opcode = OP_BEQ;
                    dec.imm    = imm_b;
                end
            end
            7'b1101111: begin
                dec.opcode = OP_JAL;
                dec.imm    = imm_j;
                dec.rd_we  = 1'b1;
            end
            default: dec.opcode = OP_ILLEGAL;
        endcase
    end

endmodule

//--- hw/rv_alu.sv
// integer alu
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t         op,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    output logic [rv_pkg::XLEN-1:0] y,
    output logic                    eq
);
    import rv_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            default: y = a + b;
        endcase
    end

    // beq compare, independent of op
    assign eq = (a == b);

endmodule

//--- hw/rv_regfile.sv
// integer register file
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    we,
    input  logic [4:0]              waddr,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    output logic [rv_pkg::XLEN-1:0] rdata1,
    output logic [rv_pkg::XLEN-1:0] rdata2
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    // x0 never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- hw/rv_mem.sv
// word memory, sync write and async read
`timescale 1ns/1ps

module rv_mem #(
    parameter int WORDS = 256
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [rv_pkg::XLEN-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    input  logic [rv_pkg::XLEN-1:0] raddr,
    output logic [rv_pkg::XLEN-1:0] rdata
);
    import rv_pkg::*;

    // index bits, addresses wrap modulo WORDS
    localparam int AW = $clog2(WORDS);

    logic [XLEN-1:0] mem [WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[AW-1:0]] <= wdata;
        end
    end

    assign rdata = mem[raddr[AW-1:0]];

endmodule

//--- golden/golden_core.sv
// single cycle reference core
`timescale 1ns/1ps

module golden_core #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               hold,
    input  rv_pkg::imem_load_t load,
    output rv_pkg::retire_t    golden_retire
);
    import rv_pkg::*;

    decoded_t        dec;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic            eq;
    logic            run;
    logic            taken;
    logic            wr_en;

    // no state changes in reset or while held
    assign run = !rst && !hold;

    rv_mem #(.WORDS(IMEM_WORDS)) u_imem (
        .clk(clk), .we(load.en),
        .waddr({{(XLEN-8){1'b0}}, load.addr}), .wdata(load.data),
        .raddr({2'b00, pc[XLEN-1:2]}), .rdata(instr)
    );

    rv_decoder u_dec (.instr(instr), .dec(dec));

    rv_regfile u_rf (
        .clk(clk), .we(run && wr_en), .waddr(dec.rd), .wdata(wb_data),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1_val), .rdata2(rs2_val)
    );

    assign alu_b = dec.use_imm ? dec.imm : rs2_val;

    rv_alu u_alu (.op(dec.alu_op), .a(rs1_val), .b(alu_b), .y(alu_y), .eq(eq));

    // lw and sw address comes out of the alu
    rv_mem #(.WORDS(DMEM_WORDS)) u_dmem (
        .clk(clk), .we(run && dec.opcode == OP_SW),
        .waddr({2'b00, alu_y[XLEN-1:2]}), .wdata(rs2_val),
        .raddr({2'b00, alu_y[XLEN-1:2]}), .rdata(load_data)
    );

    assign pc_plus4 = pc + XLEN'(4);
    assign taken    = (dec.opcode == OP_JAL) || (dec.opcode == OP_BEQ && eq);
    assign next_pc  = taken ? pc + dec.imm : pc_plus4;
    assign wr_en    = dec.rd_we && dec.rd != 5'd0;

    always_comb begin
        case (dec.opcode)
            OP_LW:   wb_data = load_data;
            OP_JAL:  wb_data = pc_plus4;
            default: wb_data = alu_y;
        endcase
    end

    // pc and retire record
    always_ff @(posedge clk) begin
        if (rst) begin
            pc            <= '0;
            golden_retire <= '0;
        end else begin
            golden_retire.valid <= !hold;
            golden_retire.pc    <= pc;
            golden_retire.rd_we <= wr_en;
            golden_retire.rd    <= wr_en ? dec.rd : 5'd0;
            golden_retire.wdata <= wr_en ? wb_data : '0;
            if (!hold) begin
                pc <= next_pc;
            end
        end
    end

endmodule

//--- segmented/segmented_core.sv
// three stage pipelined core
`timescale 1ns/1ps

module segmented_core #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::imem_load_t load,
    output rv_pkg::retire_t    seg_retire
);
    import rv_pkg::*;

    // fetch
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    // fetch/execute register
    logic [XLEN-1:0] fe_pc;
    logic [XLEN-1:0] fe_instr;
    logic            fe_valid;
    // execute
    decoded_t        dec;
    logic [XLEN-1:0] rf_a;
    logic [XLEN-1:0] rf_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] target;
    logic            eq;
    logic            taken;
    logic            wr_en;
    logic            fwd_a;
    logic            fwd_b;

    rv_mem #(.WORDS(IMEM_WORDS)) u_imem (
        .clk(clk), .we(load.en),
        .waddr({{(XLEN-8){1'b0}}, load.addr}), .wdata(load.data),
        .raddr({2'b00, pc[XLEN-1:2]}), .rdata(instr)
    );

    rv_decoder u_dec (.instr(fe_instr), .dec(dec));

    // writeback stage writes straight from the retire record
    rv_regfile u_rf (
        .clk(clk), .we(seg_retire.valid && seg_retire.rd_we),
        .waddr(seg_retire.rd), .wdata(seg_retire.wdata),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rf_a), .rdata2(rf_b)
    );

    // writeback to execute forwarding
    assign fwd_a = seg_retire.valid && seg_retire.rd_we && seg_retire.rd != 5'd0
                   && seg_retire.rd == dec.rs1;
    assign fwd_b = seg_retire.valid && seg_retire.rd_we && seg_retire.rd != 5'd0
                   && seg_retire.rd == dec.rs2;
    assign op_a  = fwd_a ? seg_retire.wdata : rf_a;
    assign op_b  = fwd_b ? seg_retire.wdata : rf_b;
    assign alu_b = dec.use_imm ? dec.imm : op_b;

    rv_alu u_alu (.op(dec.alu_op), .a(op_a), .b(alu_b), .y(alu_y), .eq(eq));

    rv_mem #(.WORDS(DMEM_WORDS)) u_dmem (
        .clk(clk), .we(fe_valid && !rst && dec.opcode == OP_SW),
        .waddr({2'b00, alu_y[XLEN-1:2]}), .wdata(op_b),
        .raddr({2'b00, alu_y[XLEN-1:2]}), .rdata(load_data)
    );

    // branch resolves in execute, bubbles never redirect
    assign taken  = fe_valid && ((dec.opcode == OP_JAL) || (dec.opcode == OP_BEQ && eq));
    assign target = fe_pc + dec.imm;
    assign wr_en  = fe_valid && dec.rd_we && dec.rd != 5'd0;

    always_comb begin
        case (dec.opcode)
            OP_LW:   wb_data = load_data;
            OP_JAL:  wb_data = fe_pc + XLEN'(4);
            default: wb_data = alu_y;
        endcase
    end

    // pc, valid bit and execute/writeback record
    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            fe_valid   <= 1'b0;
            seg_retire <= '0;
        end else begin
            pc       <= taken ? target : pc + XLEN'(4);
            // taken transfer squashes the word fetched behind it
            fe_valid <= !taken;
            seg_retire.valid <= fe_valid;
            seg_retire.pc    <= fe_pc;
            seg_retire.rd_we <= wr_en;
            seg_retire.rd    <= wr_en ? dec.rd : 5'd0;
            seg_retire.wdata <= wr_en ? wb_data : '0;
        end
    end

    // fetched word and its pc
    always_ff @(posedge clk) begin
        fe_pc    <= pc;
        fe_instr <= instr;
    end

endmodule

//--- hw/retire_checker.sv
// in order retirement comparator
`timescale 1ns/1ps

module retire_checker #(
    parameter int CHECK_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::retire_t golden_retire,
    input  rv_pkg::retire_t seg_retire,
    output logic            hold,
    output logic            mismatch
);
    import rv_pkg::*;

    localparam int PW = $clog2(CHECK_DEPTH);
    localparam int CW = $clog2(CHECK_DEPTH + 1);

    retire_t       fifo [CHECK_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;
    logic          empty;
    logic          differ;

    // pointer step with wrap at any depth
    function automatic logic [PW-1:0] bump(input logic [PW-1:0] ptr);
        return (ptr == PW'(CHECK_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty  = (count == '0);
    assign push   = golden_retire.valid;
    assign pop    = seg_retire.valid && !empty;
    // head vs segmented record, empty pop counts as a miss
    assign differ = seg_retire.valid && (empty || fifo[rd_ptr] != seg_retire);
    // record still in the golden output register takes a slot too
    assign hold   = (int'(count) + int'(golden_retire.valid)) >= CHECK_DEPTH;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= golden_retire;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            mismatch <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count + CW'(push) - CW'(pop);
            // sticky until reset
            mismatch <= mismatch || differ;
        end
    end

endmodule

//--- hw/core.sv
// lockstep rv32i core pair
`timescale 1ns/1ps

module core #(
    parameter int IMEM_WORDS  = 256,
    parameter int DMEM_WORDS  = 256,
    parameter int CHECK_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::imem_load_t load,
    output rv_pkg::retire_t    retire,
    output logic               mismatch
);
    import rv_pkg::*;

    retire_t golden_retire;
    logic    hold;

    // reference model, throttled by the checker
    golden_core #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) u_golden (
        .clk(clk), .rst(rst), .hold(hold), .load(load),
        .golden_retire(golden_retire)
    );

    // pipelined core, its record is the top level retire stream
    segmented_core #(
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) u_segmented (
        .clk(clk), .rst(rst), .load(load),
        .seg_retire(retire)
    );

    retire_checker #(
        .CHECK_DEPTH(CHECK_DEPTH)
    ) u_checker (
        .clk(clk), .rst(rst),
        .golden_retire(golden_retire), .seg_retire(retire),
        .hold(hold), .mismatch(mismatch)
    );

endmodule

//--- verification/core_assert.sv
// top level output assertions
`timescale 1ns/1ps

module core_assert (
    input logic            clk,
    input logic            rst,
    input rv_pkg::retire_t retire,
    input logic            mismatch
);

    // both outputs quiet in the cycle after reset
    reset_quiet: assert property (@(posedge clk) rst |=> !retire.valid && !mismatch)
        else $error("retire or mismatch active after reset");

    // the two cores agree on every retirement
    no_mismatch: assert property (@(posedge clk) !$rose(mismatch))
        else $error("checker flagged a retirement mismatch");

    // x0 never reported as written
    no_x0_write: assert property (
        @(posedge clk) retire.valid && retire.rd == 5'd0 |-> !retire.rd_we
    ) else $error("retire record writes x0");

endmodule

bind core core_assert u_core_assert (
    .clk(clk),
    .rst(rst),
    .retire(retire),
    .mismatch(mismatch)
);

//--- verification/core_tb.sv
// lockstep core testbench
`timescale 1ns/1ps

module core_tb;
    import rv_pkg::*;

    localparam int CLK_NS      = 20;
    localparam int TEST_COUNT  = 5;
    localparam int MAX_PROG    = 32;
    localparam int MAX_RECORDS = 64;
    // self loop retirements kept once a program settles
    localparam int LOOP_REPEAT = 2;
    // cycles one program may take to retire all its records
    localparam int RUN_LIMIT   = 4 * MAX_RECORDS + 20;
    localparam int TEST_CYCLES = MAX_PROG + 4 + RUN_LIMIT;
    localparam int WATCHDOG_NS = (TEST_COUNT * TEST_CYCLES + 100) * CLK_NS;

    logic       clk = 1'b0;
    logic       rst;
    imem_load_t load;
    retire_t    retire;
    logic       mismatch;

    // program table, fields plus encoded word
    opcode_t         p_op   [MAX_PROG];
    logic [4:0]      p_rd   [MAX_PROG];
    logic [4:0]      p_rs1  [MAX_PROG];
    logic [4:0]      p_rs2  [MAX_PROG];
    logic [XLEN-1:0] p_imm  [MAX_PROG];
    logic [XLEN-1:0] p_word [MAX_PROG];
    int              p_len;

    // architectural state, kept across programs like the cores keep it
    logic [XLEN-1:0] m_regs [32];
    logic [XLEN-1:0] m_dmem [256];
    retire_t         exp_q  [$];

    int seed = 2635;
    int errors;
    int checks;
    int failed_tests;

    core #(.IMEM_WORDS(256), .DMEM_WORDS(256), .CHECK_DEPTH(4)) u_core (
        .clk(clk), .rst(rst), .load(load), .retire(retire), .mismatch(mismatch)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // rv32i encodings straight from the isa formats
    function automatic logic [31:0] encode(input opcode_t op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        case (op)
            OP_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            OP_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            OP_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            OP_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            OP_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            OP_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            OP_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default: return 32'h0;
        endcase
    endfunction

    // signed 12 bit operand for addi
    function automatic int rand_imm();
        logic [11:0] v;
        v = 12'($random(seed));
        return {{20{v[11]}}, v};
    endfunction

    task automatic new_program();
        p_len = 0;
        for (int i = 0; i < MAX_PROG; i++) begin
            p_op[i]   = OP_ILLEGAL;
            p_rd[i]   = '0;
            p_rs1[i]  = '0;
            p_rs2[i]  = '0;
            p_imm[i]  = '0;
            p_word[i] = '0;
        end
    endtask

    task automatic add_instr(input opcode_t op, input int rd, input int rs1, input int rs2,
                             input int imm);
        p_op[p_len]   = op;
        p_rd[p_len]   = 5'(rd);
        p_rs1[p_len]  = 5'(rs1);
        p_rs2[p_len]  = 5'(rs2);
        p_imm[p_len]  = imm;
        p_word[p_len] = encode(op, 5'(rd), 5'(rs1), 5'(rs2), imm);
        p_len++;
    endtask

    // walk the program from pc 0 until the final self loop repeats
    task automatic build_expect();
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        int          idx;
        int          loops;
        retire_t     r;
        exp_q.delete();
        pc    = '0;
        loops = 0;
        while (loops < LOOP_REPEAT && exp_q.size() < MAX_RECORDS) begin
            idx  = int'(pc[31:2]);
            a    = m_regs[p_rs1[idx]];
            b    = m_regs[p_rs2[idx]];
            addr = a + p_imm[idx];
            nxt  = pc + 32'd4;
            res  = '0;
            wr   = 1'b1;
            case (p_op[idx])
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_ADDI: res = addr;
                OP_LW:   res = m_dmem[addr[9:2]];
                OP_SW: begin
                    wr = 1'b0;
                    m_dmem[addr[9:2]] = b;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nxt = pc + p_imm[idx];
                    end
                end
                OP_JAL: begin
                    res = pc + 32'd4;
                    nxt = pc + p_imm[idx];
                end
                default: wr = 1'b0;
            endcase
            // x0 stays zero, no write reported
            wr = wr && (p_rd[idx] != 5'd0);
            if (wr) begin
                m_regs[p_rd[idx]] = res;
            end
            r       = '0;
            r.valid = 1'b1;
            r.pc    = pc;
            r.rd_we = wr;
            r.rd    = wr ? p_rd[idx] : 5'd0;
            r.wdata = wr ? res : '0;
            exp_q.push_back(r);
            if (nxt == pc) begin
                loops++;
            end
            pc = nxt;
        end
    endtask

    task automatic run_program(input string name);
        int   err_start;
        int   seen;
        int   cycles;
        logic bubble_due;
        err_start  = errors;
        seen       = 0;
        cycles     = 0;
        bubble_due = 1'b0;
        build_expect();
        // program goes in under reset
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < p_len; i++) begin
            load.en   = 1'b1;
            load.addr = 8'(i);
            load.data = p_word[i];
            @(negedge clk);
        end
        load = '0;
        repeat (2) begin
            @(negedge clk);
            check("valid in reset", 32'(retire.valid), 32'd0);
            check("mismatch in reset", 32'(mismatch), 32'd0);
        end
        rst = 1'b0;
        while (seen < exp_q.size() && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            // slot behind a taken transfer is a bubble
            if (bubble_due) begin
                check("flushed slot retired", 32'(retire.valid), 32'd0);
                bubble_due = 1'b0;
            end
            if (retire.valid) begin
                if (seen == 0) begin
                    check("first retire cycle", 32'(cycles), 32'd2);
                end
                check("pc", retire.pc, exp_q[seen].pc);
                check("rd_we", 32'(retire.rd_we), 32'(exp_q[seen].rd_we));
                check("rd", 32'(retire.rd), 32'(exp_q[seen].rd));
                check("wdata", retire.wdata, exp_q[seen].wdata);
                if (seen + 1 < exp_q.size()) begin
                    bubble_due = (exp_q[seen + 1].pc != exp_q[seen].pc + 32'd4);
                end
                seen++;
            end
        end
        if (seen < exp_q.size()) begin
            errors++;
            $display("%s: no progress, %0d of %0d records retired in %0d cycles",
                     name, seen, exp_q.size(), cycles);
        end
        // compare result lands one cycle later
        @(negedge clk);
        check("mismatch", 32'(mismatch), 32'd0);
        if (errors != err_start) begin
            failed_tests++;
        end
        $display("%s: %s, %0d records, %0d errors", name,
                 (errors == err_start) ? "PASS" : "FAIL", seen, errors - err_start);
    endtask

    task automatic reset_state();
        new_program();
        add_instr(OP_ADDI, 1, 0, 0, 5);
        add_instr(OP_ADDI, 2, 1, 0, 7);
        add_instr(OP_JAL, 0, 0, 0, 0);
        run_program("reset_state");
    endtask

    // every op reads the result just before it
    task automatic alu_chain();
        int r1;
        int r2;
        r1 = rand_imm();
        r2 = rand_imm();
        new_program();
        add_instr(OP_ADDI, 1, 0, 0, r1);
        add_instr(OP_ADDI, 2, 1, 0, r2);
        add_instr(OP_ADD, 3, 2, 1, 0);
        add_instr(OP_SUB, 4, 3, 2, 0);
        add_instr(OP_AND, 5, 4, 3, 0);
        add_instr(OP_OR, 6, 5, 2, 0);
        add_instr(OP_ADD, 7, 6, 6, 0);
        add_instr(OP_SUB, 8, 0, 7, 0);
        add_instr(OP_JAL, 0, 0, 0, 0);
        run_program("alu_chain");
    endtask

    task automatic memory_access();
        int r1;
        int r2;
        r1 = rand_imm();
        r2 = rand_imm();
        new_program();
        add_instr(OP_ADDI, 1, 0, 0, r1);
        add_instr(OP_ADDI, 2, 0, 0, r2);
        add_instr(OP_ADDI, 10, 0, 0, 64);
        add_instr(OP_SW, 0, 10, 1, 0);
        add_instr(OP_SW, 0, 10, 2, 8);
        add_instr(OP_LW, 3, 10, 0, 0);
        add_instr(OP_LW, 4, 10, 0, 8);
        // store data forwarded from the load just before
        add_instr(OP_SW, 0, 10, 4, 4);
        add_instr(OP_LW, 5, 10, 0, 4);
        add_instr(OP_ADD, 6, 3, 5, 0);
        add_instr(OP_JAL, 0, 0, 0, 0);
        run_program("memory_access");
    endtask

    task automatic control_flow();
        new_program();
        add_instr(OP_ADDI, 1, 0, 0, 3);
        add_instr(OP_ADDI, 2, 0, 0, 3);
        add_instr(OP_BEQ, 0, 1, 2, 8);
        add_instr(OP_ADDI, 3, 0, 0, 1);
        add_instr(OP_BEQ, 0, 1, 0, 8);
        add_instr(OP_ADDI, 4, 0, 0, 9);
        // link lands in x5, skipped addi never retires
        add_instr(OP_JAL, 5, 0, 0, 8);
        add_instr(OP_ADDI, 4, 0, 0, 1);
        add_instr(OP_ADD, 6, 5, 4, 0);
        add_instr(OP_JAL, 0, 0, 0, 0);
        run_program("control_flow");
    endtask

    // taken branch heavy run, golden core fills the checker fifo and waits
    task automatic lockstep_run();
        new_program();
        add_instr(OP_ADDI, 10, 0, 0, 64);
        add_instr(OP_LW, 7, 10, 0, 8);
        add_instr(OP_ADDI, 1, 0, 0, 0);
        add_instr(OP_ADDI, 2, 0, 0, 8);
        add_instr(OP_ADDI, 1, 1, 0, 1);
        add_instr(OP_BEQ, 0, 1, 2, 8);
        add_instr(OP_JAL, 0, 0, 0, -8);
        for (int i = 0; i < 6; i++) begin
            add_instr(OP_JAL, 0, 0, 0, 4);
        end
        add_instr(OP_ADD, 8, 7, 1, 0);
        add_instr(OP_JAL, 0, 0, 0, 0);
        run_program("lockstep_run");
    endtask

    initial begin
        rst          = 1'b1;
        load         = '0;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            m_dmem[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset_state();
        alu_chain();
        memory_access();
        control_flow();
        lockstep_run();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 TEST_COUNT, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // hard stop if a program never settles
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- core.f
common/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_mem.sv
golden/golden_core.sv
segmented/segmented_core.sv
hw/retire_checker.sv
hw/core.sv
verification/core_assert.sv
verification/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lockstep testbench, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f core.f -o core_tb_sim \
    && ./obj_dir/core_tb_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
